// ==== hw/ghash_msg_and_h_pow_picker.sv ====
`timescale 1ns/100ps

module ghash_msg_and_h_pow_picker
#(
    parameter int NB_BLOCK = ghash_pkg::DEFAULT_NB_BLOCK
)
(
    input  logic                                    i_clock,
    input  logic                                    i_reset,
    input  logic [2*NB_BLOCK-1:0]                   i_data,          // block 0 in low half
    input  logic [ghash_pkg::N_H_POW*NB_BLOCK-1:0]  i_h_key_powers,
    input  logic [NB_BLOCK-1:0]                     i_feedback,
    input  logic [NB_BLOCK-1:0]                     i_mod_prod,
    input  ghash_pkg::stage_t                       i_stage,
    input  ghash_pkg::bubbles_t                     i_msg_bubbles,
    input  logic                                    i_hold_msg,
    input  logic                                    i_last_cycle,
    input  logic                                    i_valid,
    output logic [NB_BLOCK-1:0]                     o_m0,
    output logic [NB_BLOCK-1:0]                     o_m1,
    output logic [2*NB_BLOCK-1:0]                   o_h_pow
);

    import ghash_pkg::*;

    logic                           w_shift;
    logic                           w_load;
    logic                           w_use_input;
    logic                           w_blank;
    logic                           w_msg_present;
    logic                           w_inject_feedback;
    logic                           w_pair_present;
    buf_sel_t                       w_buf_sel;
    pair_sel_t                      w_pair_sel;
    logic [N_STAGES*2*NB_BLOCK-1:0] w_buf_words;     // all held words, entry 0 low

    // decodes the tail control
    ghash_tail_planner u_tail_planner
    (
        .i_valid            (i_valid),
        .i_hold_msg         (i_hold_msg),
        .i_last_cycle       (i_last_cycle),
        .i_stage            (i_stage),
        .i_msg_bubbles      (i_msg_bubbles),
        .o_shift            (w_shift),
        .o_load             (w_load),
        .o_use_input        (w_use_input),
        .o_blank            (w_blank),
        .o_msg_present      (w_msg_present),
        .o_inject_feedback  (w_inject_feedback),
        .o_pair_present     (w_pair_present),
        .o_buf_sel          (w_buf_sel),
        .o_pair_sel         (w_pair_sel)
    );

    ghash_msg_buffer
    #(
        .NB_BLOCK   (NB_BLOCK)
    )
    u_msg_buffer
    (
        .i_clock    (i_clock),
        .i_reset    (i_reset),
        .i_shift    (w_shift),
        .i_data     (i_data),
        .o_words    (w_buf_words)
    );

    // output register stage
    ghash_operand_picker
    #(
        .NB_BLOCK   (NB_BLOCK)
    )
    u_operand_picker
    (
        .i_clock            (i_clock),
        .i_reset            (i_reset),
        .i_load             (w_load),
        .i_use_input        (w_use_input),
        .i_blank            (w_blank),
        .i_msg_present      (w_msg_present),
        .i_inject_feedback  (w_inject_feedback),
        .i_pair_present     (w_pair_present),
        .i_buf_sel          (w_buf_sel),
        .i_pair_sel         (w_pair_sel),
        .i_data             (i_data),
        .i_words            (w_buf_words),
        .i_h_key_powers     (i_h_key_powers),
        .i_feedback         (i_feedback),
        .i_mod_prod         (i_mod_prod),
        .o_m0               (o_m0),
        .o_m1               (o_m1),
        .o_h_pow            (o_h_pow)
    );

endmodule

// ==== hw/ghash_msg_buffer.sv ====
`timescale 1ns/100ps

module ghash_msg_buffer
#(
    parameter int NB_BLOCK = ghash_pkg::DEFAULT_NB_BLOCK
)
(
    input  logic                                        i_clock,
    input  logic                                        i_reset,
    input  logic                                        i_shift,
    input  logic [2*NB_BLOCK-1:0]                       i_data,
    output logic [ghash_pkg::N_STAGES*2*NB_BLOCK-1:0]   o_words
);

    import ghash_pkg::*;

    localparam int NB_DATA = 2*NB_BLOCK;

    logic [NB_DATA-1:0] buf_q [N_STAGES];  // entry 0 newest

    always_ff @(posedge i_clock)
    begin
        if (i_reset)
        begin
            for (int i = 0; i < N_STAGES; i++)
            begin
                buf_q[i] <= '0;
            end
        end
        else if (i_shift)
        begin
            buf_q[0] <= i_data;            // held word enters here
            for (int i = 1; i < N_STAGES; i++)
            begin
                buf_q[i] <= buf_q[i-1];    // older words move up
            end
        end
    end

    // flatten for the picker
    always_comb
    begin
        for (int i = 0; i < N_STAGES; i++)
        begin
            o_words[i*NB_DATA +: NB_DATA] = buf_q[i];
        end
    end

endmodule

// ==== hw/ghash_operand_picker.sv ====
`timescale 1ns/100ps

module ghash_operand_picker
#(
    parameter int NB_BLOCK = ghash_pkg::DEFAULT_NB_BLOCK
)
(
    input  logic                                        i_clock,
    input  logic                                        i_reset,
    input  logic                                        i_load,
    input  logic                                        i_use_input,
    input  logic                                        i_blank,
    input  logic                                        i_msg_present,
    input  logic                                        i_inject_feedback,
    input  logic                                        i_pair_present,
    input  ghash_pkg::buf_sel_t                         i_buf_sel,
    input  ghash_pkg::pair_sel_t                        i_pair_sel,
    input  logic [2*NB_BLOCK-1:0]                       i_data,
    input  logic [ghash_pkg::N_STAGES*2*NB_BLOCK-1:0]   i_words,
    input  logic [ghash_pkg::N_H_POW*NB_BLOCK-1:0]      i_h_key_powers,
    input  logic [NB_BLOCK-1:0]                         i_feedback,
    input  logic [NB_BLOCK-1:0]                         i_mod_prod,
    output logic [NB_BLOCK-1:0]                         o_m0,
    output logic [NB_BLOCK-1:0]                         o_m1,
    output logic [2*NB_BLOCK-1:0]                       o_h_pow
);

    localparam int NB_DATA = 2*NB_BLOCK;

    logic [NB_DATA-1:0]  msg_word;     // input or replayed word
    logic [NB_DATA-1:0]  msg_masked;   // zero for idle stages
    logic [NB_BLOCK-1:0] fold_term;    // feedback plus modular product
    logic [NB_BLOCK-1:0] m0_next;
    logic [NB_BLOCK-1:0] m1_next;
    logic [NB_DATA-1:0]  h_pow_next;

    // message path
    always_comb
    begin
        if (i_use_input)
        begin
            msg_word = i_data;
        end
        else
        begin
            msg_word = i_words[i_buf_sel*NB_DATA +: NB_DATA];
        end

        if (i_msg_present)
        begin
            msg_masked = msg_word;
        end
        else
        begin
            msg_masked = '0;
        end

        if (i_inject_feedback)
        begin
            fold_term = i_feedback ^ i_mod_prod;
        end
        else
        begin
            fold_term = '0;
        end
    end

    // key powers and blanking
    always_comb
    begin
        m0_next = msg_masked[0 +: NB_BLOCK] ^ fold_term;   // block 0 takes the fold
        m1_next = msg_masked[NB_BLOCK +: NB_BLOCK];

        if (i_pair_present)
        begin
            h_pow_next = i_h_key_powers[i_pair_sel*NB_DATA +: NB_DATA];
        end
        else
        begin
            h_pow_next = '0;
        end

        if (i_blank)
        begin
            m0_next    = '0;     // tail words are still arriving
            m1_next    = '0;
            h_pow_next = '0;
        end
    end

    always_ff @(posedge i_clock)
    begin
        if (i_reset)
        begin
            o_m0    <= '0;
            o_m1    <= '0;
            o_h_pow <= '0;
        end
        else if (i_load)
        begin
            o_m0    <= m0_next;
            o_m1    <= m1_next;
            o_h_pow <= h_pow_next;
        end
    end

endmodule

// ==== hw/ghash_pkg.sv ====
package ghash_pkg;

    // drain geometry, fixed by the four-stage multiplier chain
    localparam int N_STAGES = 4;           // stages per drain, also buffer depth
    localparam int N_H_POW  = 8;           // key powers supplied, two per stage

    localparam int DEFAULT_NB_BLOCK = 128; // gcm block width

    // index of the multiplier stage that takes this cycle's operands
    typedef logic [1:0] stage_t;

    // missing tail words
    // 0 means a full set of four, any other value is the count present
    typedef logic [1:0] bubbles_t;

    // message buffer entry, 3 is the oldest
    typedef logic [1:0] buf_sel_t;

    // key-power pair k covers powers 2k and 2k+1
    typedef logic [1:0] pair_sel_t;

endpackage

// ==== hw/ghash_tail_planner.sv ====
`timescale 1ns/100ps

module ghash_tail_planner
(
    input  logic                  i_valid,
    input  logic                  i_hold_msg,
    input  logic                  i_last_cycle,
    input  ghash_pkg::stage_t     i_stage,
    input  ghash_pkg::bubbles_t   i_msg_bubbles,
    output logic                  o_shift,
    output logic                  o_load,
    output logic                  o_use_input,
    output logic                  o_blank,
    output logic                  o_msg_present,
    output logic                  o_inject_feedback,
    output logic                  o_pair_present,
    output ghash_pkg::buf_sel_t   o_buf_sel,
    output ghash_pkg::pair_sel_t  o_pair_sel
);

    import ghash_pkg::*;

    logic [2:0] words_present;   // 1 to 4 tail words
    stage_t     first_stage;     // first stage fed from the buffer
    stage_t     stage_offset;    // distance from first_stage

    assign o_shift = i_valid & i_hold_msg;
    assign o_load  = i_valid;

    always_comb
    begin
        if (i_msg_bubbles == '0)
        begin
            words_present = 3'(N_STAGES);
        end
        else
        begin
            words_present = {1'b0, i_msg_bubbles};
        end
        first_stage  = stage_t'(N_STAGES - words_present);
        stage_offset = i_stage - first_stage;
    end

    // operand selection per stage
    always_comb
    begin
        o_use_input       = 1'b0;
        o_blank           = 1'b0;
        o_msg_present     = 1'b0;
        o_inject_feedback = 1'b0;
        o_pair_present    = 1'b0;
        o_buf_sel         = buf_sel_t'(N_STAGES - 1);
        o_pair_sel        = pair_sel_t'(N_STAGES - 1 - i_stage);  // descending powers

        if (!i_last_cycle)
        begin
            o_use_input    = 1'b1;                    // plain streaming
            o_msg_present  = 1'b1;
            o_pair_present = 1'b1;
        end
        else if (i_hold_msg)
        begin
            o_blank = 1'b1;                           // still collecting the tail
        end
        else
        begin
            o_inject_feedback = (i_stage == '0);      // fold running hash into stage 0
            if (i_stage >= first_stage)
            begin
                // oldest buffered word goes to the first busy stage
                o_buf_sel      = buf_sel_t'(N_STAGES - 1 - stage_offset);
                o_msg_present  = 1'b1;
                o_pair_present = 1'b1;
            end
            else if (i_stage == '0)
            begin
                o_pair_sel     = pair_sel_t'(words_present - 1);  // feedback only
                o_pair_present = 1'b1;
            end
        end
    end

endmodule

// ==== project.f ====
hw/ghash_pkg.sv
hw/ghash_msg_buffer.sv
hw/ghash_tail_planner.sv
hw/ghash_operand_picker.sv
hw/ghash_msg_and_h_pow_picker.sv
verification/tb_ghash_picker.sv

// ==== verification/tb_ghash_picker.sv ====
`timescale 1ns/100ps

module tb_ghash_picker;

    import ghash_pkg::*;

    localparam int NB            = DEFAULT_NB_BLOCK;
    localparam int CLOCK_PERIOD  = 40;
    localparam int RESET_CYCLES  = 16;
    localparam int IDLE_CYCLES   = 4;
    localparam int STREAM_CYCLES = 40;
    localparam int GAP_CYCLES    = 1;
    // holds for a full set and tails of 1, 2 and 3 words, then four drain stages each
    localparam int TAIL_CYCLES   = N_STAGES + (1 + 2 + 3) + 4*N_STAGES;
    localparam int TEST_CYCLES   = RESET_CYCLES + IDLE_CYCLES + STREAM_CYCLES
                                   + TAIL_CYCLES + GAP_CYCLES + 2;
    localparam int CYCLE_LIMIT   = 2*TEST_CYCLES;

    logic                  i_clock;
    logic                  i_reset;
    logic [2*NB-1:0]       i_data;
    logic [N_H_POW*NB-1:0] i_h_key_powers;
    logic [NB-1:0]         i_feedback;
    logic [NB-1:0]         i_mod_prod;
    stage_t                i_stage;
    bubbles_t              i_msg_bubbles;
    logic                  i_hold_msg;
    logic                  i_last_cycle;
    logic                  i_valid;
    logic [NB-1:0]         o_m0;
    logic [NB-1:0]         o_m1;
    logic [2*NB-1:0]       o_h_pow;

    logic [2*NB-1:0] model_buf [N_STAGES];  // entry 0 newest
    logic [NB-1:0]   exp_m0;
    logic [NB-1:0]   exp_m1;
    logic [2*NB-1:0] exp_h_pow;
    string           test_name;
    logic            check_en;
    logic [31:0]     lfsr_state;
    int              cycle_count;

    ghash_msg_and_h_pow_picker
    #(
        .NB_BLOCK   (NB)
    )
    u_ghash_msg_and_h_pow_picker
    (
        .i_clock        (i_clock),
        .i_reset        (i_reset),
        .i_data         (i_data),
        .i_h_key_powers (i_h_key_powers),
        .i_feedback     (i_feedback),
        .i_mod_prod     (i_mod_prod),
        .i_stage        (i_stage),
        .i_msg_bubbles  (i_msg_bubbles),
        .i_hold_msg     (i_hold_msg),
        .i_last_cycle   (i_last_cycle),
        .i_valid        (i_valid),
        .o_m0           (o_m0),
        .o_m1           (o_m1),
        .o_h_pow        (o_h_pow)
    );

    initial
    begin
        i_clock = 1'b0;
        forever
        begin
            #(CLOCK_PERIOD/2) i_clock = ~i_clock;
        end
    end

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic next_bit();
        logic fb;
        fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};
        return fb;
    endfunction

    function automatic logic [NB-1:0] random_block();
        logic [NB-1:0] v;
        for (int i = 0; i < NB; i++)
        begin
            v[i] = next_bit();
        end
        return v;
    endfunction

    function automatic logic [1:0] random_field();
        logic [1:0] v;
        v[0] = next_bit();
        v[1] = next_bit();
        return v;
    endfunction

    function automatic logic [2*NB-1:0] key_pair(input int k);
        return i_h_key_powers[k*2*NB +: 2*NB];   // powers 2k and 2k+1
    endfunction

    // expected {h_pow, m1, m0} after the next rising edge
    // works on the stimulus now applied and the held words before that edge
    function automatic logic [4*NB-1:0] expected_outputs
    (
        input logic valid,
        input logic hold,
        input logic last,
        input int   stage,
        input int   bubbles
    );
        logic [2*NB-1:0] msg;
        logic [NB-1:0]   fold;
        logic [2*NB-1:0] pair;
        int              n;
        int              first;

        if (!valid)
        begin
            return {exp_h_pow, exp_m1, exp_m0};   // registers keep their value
        end
        msg  = '0;
        fold = '0;
        pair = '0;
        if (!last)
        begin
            msg  = i_data;
            pair = key_pair(N_STAGES - 1 - stage);
        end
        else if (!hold)
        begin
            n     = (bubbles == 0) ? N_STAGES : bubbles;
            first = N_STAGES - n;
            if (stage == 0)
            begin
                fold = i_feedback ^ i_mod_prod;
            end
            if (stage >= first)
            begin
                msg  = model_buf[N_STAGES - 1 - (stage - first)];  // oldest first
                pair = key_pair(N_STAGES - 1 - stage);
            end
            else if (stage == 0)
            begin
                pair = key_pair(n - 1);
            end
        end
        return {pair, msg[2*NB-1:NB], msg[NB-1:0] ^ fold};
    endfunction

    task automatic check_value
    (
        input string           name,
        input logic [4*NB-1:0] expected,
        input logic [4*NB-1:0] actual
    );
        if (actual !== expected)
        begin
            $display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
            $display("CHECKS FAILED");
            $fatal(1);
        end
    endtask

    task automatic drive_cycle
    (
        input string      name,
        input logic       valid,
        input logic       hold,
        input logic       last,
        input logic [1:0] stage,
        input logic [1:0] bubbles
    );
        logic [4*NB-1:0] expected;

        @(negedge i_clock);
        i_data = {random_block(), random_block()};
        for (int k = 0; k < N_H_POW; k++)
        begin
            i_h_key_powers[k*NB +: NB] = random_block();
        end
        i_feedback    = random_block();
        i_mod_prod    = random_block();
        i_valid       = valid;
        i_hold_msg    = hold;
        i_last_cycle  = last;
        i_stage       = stage;
        i_msg_bubbles = bubbles;

        expected = expected_outputs(valid, hold, last, stage, bubbles);
        if (valid && hold)
        begin
            for (int i = N_STAGES - 1; i > 0; i--)
            begin
                model_buf[i] = model_buf[i-1];
            end
            model_buf[0] = i_data;
        end
        exp_m0    = expected[0 +: NB];
        exp_m1    = expected[NB +: NB];
        exp_h_pow = expected[2*NB +: 2*NB];
        test_name = name;
    endtask

    // hold the tail words, then drain stages 0 to 3
    task automatic run_drain(input string name, input logic [1:0] bubbles, input int gap_after);
        int n_words;

        n_words = (bubbles == 0) ? N_STAGES : bubbles;
        for (int i = 0; i < n_words; i++)
        begin
            drive_cycle({name, " hold"}, 1'b1, 1'b1, 1'b1, random_field(), bubbles);
        end
        for (int s = 0; s < N_STAGES; s++)
        begin
            drive_cycle(name, 1'b1, 1'b0, 1'b1, 2'(s), bubbles);
            if (s == gap_after)
            begin
                // would shift and stream if it were valid
                drive_cycle({name, " gap"}, 1'b0, 1'b1, 1'b0, random_field(), random_field());
            end
        end
    endtask

    // compare after each rising edge
    initial
    begin
        forever
        begin
            @(posedge i_clock);
            #1;
            if (check_en)
            begin
                check_value(test_name, {exp_h_pow, exp_m1, exp_m0}, {o_h_pow, o_m1, o_m0});
            end
        end
    end

    initial
    begin
        cycle_count = 0;
        while (cycle_count < CYCLE_LIMIT)
        begin
            @(posedge i_clock);
            cycle_count++;
        end
        $display("timeout: the run did not finish within %0d clock cycles", CYCLE_LIMIT);
        $display("CHECKS FAILED");
        $fatal(1);
    end

    initial
    begin
        lfsr_state     = 32'hba66ac24;
        check_en       = 1'b0;
        test_name      = "after reset";
        i_reset        = 1'b1;
        i_data         = '0;
        i_h_key_powers = '0;
        i_feedback     = '0;
        i_mod_prod     = '0;
        i_stage        = '0;
        i_msg_bubbles  = '0;
        i_hold_msg     = 1'b0;
        i_last_cycle   = 1'b0;
        i_valid        = 1'b0;
        exp_m0         = '0;
        exp_m1         = '0;
        exp_h_pow      = '0;
        for (int i = 0; i < N_STAGES; i++)
        begin
            model_buf[i] = '0;
        end

        repeat (RESET_CYCLES) @(negedge i_clock);
        i_reset  = 1'b0;
        check_en = 1'b1;

        for (int i = 0; i < IDLE_CYCLES; i++)
        begin
            drive_cycle("idle after reset", 1'b0, next_bit(), next_bit(),
                        random_field(), random_field());
        end

        for (int i = 0; i < STREAM_CYCLES; i++)
        begin
            drive_cycle("streaming", 1'b1, 1'b0, 1'b0, random_field(), random_field());
        end

        run_drain("full drain", 2'd0, -1);
        run_drain("drain bubbles 1", 2'd1, -1);
        run_drain("drain bubbles 2", 2'd2, 1);     // idle cycle between stages 1 and 2
        run_drain("drain bubbles 3", 2'd3, -1);

        drive_cycle("final idle", 1'b0, 1'b0, 1'b0, 2'd0, 2'd0);
        @(posedge i_clock);
        #2;

        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule
